// ==== hist_pkg.sv ====
`default_nettype none

package hist_pkg;

    // histogram geometry
    // 16 bins per pixel, 4 pixels per bank
    localparam int bin_w   = 4;
    localparam int pix_w   = 2;
    localparam int count_w = 8;

    typedef logic [bin_w-1:0]   bin_t;
    typedef logic [pix_w-1:0]   pix_t;
    typedef logic [count_w-1:0] count_t;

    // memory address, bank bit on top so each bank is one contiguous half
    typedef struct packed {
        logic bank;
        pix_t pix;
        bin_t bin;
    } hist_addr_t;

    // read request into the arbiter
    typedef struct packed {
        logic       valid;
        hist_addr_t addr;
    } mem_rd_req_t;

    // write request into the arbiter
    typedef struct packed {
        logic       valid;
        hist_addr_t addr;
        count_t     data;
    } mem_wr_req_t;

    // one bin of a finished histogram
    typedef struct packed {
        logic   bank;
        pix_t   pix;
        bin_t   bin;
        count_t count;
    } ro_beat_t;

    // port owner seen by both engines
    typedef enum logic [1:0] {
        grant_none    = 2'd0,
        grant_builder = 2'd1,
        grant_readout = 2'd2
    } grant_e;

    // readout engine states
    typedef enum logic [1:0] {
        ro_idle  = 2'd0,
        ro_scan  = 2'd1,
        ro_drain = 2'd2
    } ro_state_e;

endpackage

`default_nettype wire

// ==== hist_bin_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module hist_bin_ram (
    input  wire                  clk,
    input  wire                  combin_res,
    input  hist_pkg::mem_rd_req_t ram_rd,
    input  hist_pkg::mem_wr_req_t ram_wr,
    output hist_pkg::count_t      rd_data
);
    import hist_pkg::*;

    // both banks in one array, bank bit is the address msb
    localparam int depth = 2 ** $bits(hist_addr_t);

    count_t mem [depth];

    // whole array cleared on reset, so every bin starts at zero
    // read is registered, one cycle latency
    // same-address read and write returns the old count
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (ram_wr.valid) begin
                mem[ram_wr.addr] <= ram_wr.data;
            end
            if (ram_rd.valid) begin
                rd_data <= mem[ram_rd.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hist_mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module hist_mem_arbiter (
    input  hist_pkg::mem_rd_req_t bld_rd,
    input  hist_pkg::mem_rd_req_t ro_rd,
    input  hist_pkg::mem_wr_req_t bld_wr,
    input  hist_pkg::mem_wr_req_t ro_wr,
    output hist_pkg::mem_rd_req_t ram_rd,
    output hist_pkg::mem_wr_req_t ram_wr,
    output hist_pkg::grant_e      rd_grant,
    output hist_pkg::grant_e      wr_grant
);
    import hist_pkg::*;

    // fixed priority, builder first
    // readout only gets a port the builder leaves idle
    function automatic grant_e pick_owner(input logic bld_req, input logic ro_req);
        if (bld_req) begin
            return grant_builder;
        end
        if (ro_req) begin
            return grant_readout;
        end
        return grant_none;
    endfunction

    // each port decided on its own, same cycle
    assign rd_grant = pick_owner(bld_rd.valid, ro_rd.valid);
    assign wr_grant = pick_owner(bld_wr.valid, ro_wr.valid);

    // read port mux
    always_comb begin
        case (rd_grant)
            grant_builder: ram_rd = bld_rd;
            grant_readout: ram_rd = ro_rd;
            default:       ram_rd = '0;
        endcase
    end

    // write port mux
    always_comb begin
        case (wr_grant)
            grant_builder: ram_wr = bld_wr;
            grant_readout: ram_wr = ro_wr;
            default:       ram_wr = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hist_builder.sv ====
`timescale 1ns/10ps
`default_nettype none

module hist_builder #(
    parameter int HITS_PER_PIXEL  = 3,
    parameter int FRAMES_PER_HIST = 2
) (
    input  wire                   clk,
    input  wire                   combin_res,
    input  wire                   hit_valid,
    input  hist_pkg::bin_t        hit_bin,
    output hist_pkg::mem_rd_req_t bld_rd,
    output hist_pkg::mem_wr_req_t bld_wr,
    input  hist_pkg::count_t      rd_data,
    output logic                  hist_done,
    output logic                  done_bank,
    output logic                  active_bank
);
    import hist_pkg::*;

    localparam int in_w  = (HITS_PER_PIXEL > 1) ? $clog2(HITS_PER_PIXEL) : 1;
    localparam int frm_w = (FRAMES_PER_HIST > 1) ? $clog2(FRAMES_PER_HIST) : 1;

    logic [in_w-1:0]  in_cnt;
    pix_t             pix_cnt;
    logic [frm_w-1:0] frm_cnt;
    // bank used for addressing, flips on the last hit itself
    logic             fill_bank;
    logic             last_hit;

    // pipeline: s1 waits for ram data, s2 is the write, lst the write just landed
    mem_rd_req_t s1;
    logic        s1_last;
    mem_wr_req_t s2;
    logic        s2_last;
    mem_wr_req_t lst;
    count_t      base;

    // hit goes straight to the read port, builder never loses it
    assign bld_rd = '{valid: hit_valid, addr: '{bank: fill_bank, pix: pix_cnt, bin: hit_bin}};
    assign bld_wr = s2;

    assign last_hit = hit_valid && (in_cnt == in_w'(HITS_PER_PIXEL - 1)) &&
                      (pix_cnt == '1) && (frm_cnt == frm_w'(FRAMES_PER_HIST - 1));

    // ram misses the write in flight and the one landing with our read
    // newest write wins
    always_comb begin
        if (s2.valid && (s2.addr == s1.addr)) begin
            base = s2.data;
        end else if (lst.valid && (lst.addr == s1.addr)) begin
            base = lst.data;
        end else begin
            base = rd_data;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            in_cnt      <= '0;
            pix_cnt     <= '0;
            frm_cnt     <= '0;
            fill_bank   <= 1'b0;
            s1          <= '0;
            s1_last     <= 1'b0;
            s2          <= '0;
            s2_last     <= 1'b0;
            lst         <= '0;
            hist_done   <= 1'b0;
            done_bank   <= 1'b0;
            active_bank <= 1'b0;
        end else begin
            // nested counters: hits per pixel, pixels per frame, frames per hist
            if (hit_valid) begin
                if (in_cnt == in_w'(HITS_PER_PIXEL - 1)) begin
                    in_cnt  <= '0;
                    pix_cnt <= pix_cnt + 1'b1;
                    if (pix_cnt == '1) begin
                        if (frm_cnt == frm_w'(FRAMES_PER_HIST - 1)) begin
                            frm_cnt   <= '0;
                            fill_bank <= ~fill_bank;
                        end else begin
                            frm_cnt <= frm_cnt + 1'b1;
                        end
                    end
                end else begin
                    in_cnt <= in_cnt + 1'b1;
                end
            end
            s1      <= bld_rd;
            s1_last <= last_hit;
            // increment stage
            s2      <= '{valid: s1.valid, addr: s1.addr, data: base + 1'b1};
            s2_last <= s1.valid && s1_last;
            lst     <= s2;
            // done with the cycle after the last write is issued
            hist_done <= s2.valid && s2_last;
            if (s2.valid && s2_last) begin
                done_bank   <= s2.addr.bank;
                active_bank <= ~active_bank;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hist_readout.sv ====
`timescale 1ns/10ps
`default_nettype none

module hist_readout (
    input  wire                   clk,
    input  wire                   combin_res,
    input  wire                   hist_done,
    input  wire                   done_bank,
    output hist_pkg::mem_rd_req_t ro_rd,
    output hist_pkg::mem_wr_req_t ro_wr,
    input  hist_pkg::grant_e      rd_grant,
    input  hist_pkg::grant_e      wr_grant,
    input  hist_pkg::count_t      rd_data,
    output logic                  ro_valid,
    output hist_pkg::ro_beat_t    ro_beat,
    output logic                  ro_busy
);
    import hist_pkg::*;

    localparam int idx_w = pix_w + bin_w;

    ro_state_e        state;
    ro_state_e        state_nxt;
    logic             ro_bank;
    // pixel-major scan position, pixel in the upper bits
    logic [idx_w-1:0] scan_idx;
    // read granted last cycle, its data is on rd_data now
    mem_rd_req_t      rtn;
    // clear write that lost the port
    mem_rd_req_t      pend;
    logic             wr_denied;
    logic             rd_won;

    // pending clear goes first, new beats only come when it is gone
    always_comb begin
        if (pend.valid) begin
            ro_wr = '{valid: 1'b1, addr: pend.addr, data: '0};
        end else begin
            ro_wr = '{valid: rtn.valid, addr: rtn.addr, data: '0};
        end
    end

    assign wr_denied = ro_wr.valid && (wr_grant != grant_readout);

    // hold off reads while a clear is stuck, one pending slot is enough
    assign ro_rd.valid = (state == ro_scan) && !pend.valid && !wr_denied;
    assign ro_rd.addr  = {ro_bank, scan_idx};
    assign rd_won      = ro_rd.valid && (rd_grant == grant_readout);

    // beat shows up with the ram data, one cycle after the granted read
    assign ro_valid = rtn.valid;
    assign ro_beat  = '{bank: rtn.addr.bank, pix: rtn.addr.pix, bin: rtn.addr.bin,
                        count: rd_data};
    assign ro_busy  = (state != ro_idle);

    always_comb begin
        state_nxt = state;
        case (state)
            ro_idle: begin
                if (hist_done) begin
                    state_nxt = ro_scan;
                end
            end
            ro_scan: begin
                if (rd_won && (scan_idx == '1)) begin
                    state_nxt = ro_drain;
                end
            end
            // last beat out, wait for its clear
            ro_drain: begin
                if (!wr_denied) begin
                    state_nxt = ro_idle;
                end
            end
            default: state_nxt = ro_idle;
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= ro_idle;
            ro_bank  <= 1'b0;
            scan_idx <= '0;
            rtn      <= '0;
            pend     <= '0;
        end else begin
            state <= state_nxt;
            if ((state == ro_idle) && hist_done) begin
                ro_bank  <= done_bank;
                scan_idx <= '0;
            end else if (rd_won) begin
                scan_idx <= scan_idx + 1'b1;
            end
            // lost read keeps scan_idx, retried next cycle
            rtn  <= '{valid: rd_won, addr: ro_rd.addr};
            pend <= '{valid: wr_denied, addr: ro_wr.addr};
        end
    end

endmodule

`default_nettype wire

// ==== hist_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module hist_top #(
    parameter int HITS_PER_PIXEL  = 3,
    parameter int FRAMES_PER_HIST = 2
) (
    input  wire                clk,
    input  wire                combin_res,
    input  wire                hit_valid,
    input  hist_pkg::bin_t     hit_bin,
    output logic               hist_done,
    output logic               active_bank,
    output logic               ro_valid,
    output hist_pkg::ro_beat_t ro_beat,
    output logic               ro_busy
);
    import hist_pkg::*;

    // engine requests into the arbiter
    mem_rd_req_t bld_rd;
    mem_wr_req_t bld_wr;
    mem_rd_req_t ro_rd;
    mem_wr_req_t ro_wr;
    // arbiter to ram
    mem_rd_req_t ram_rd;
    mem_wr_req_t ram_wr;
    grant_e      rd_grant;
    grant_e      wr_grant;
    // shared by both engines
    count_t      rd_data;
    logic        done_bank;

    hist_bin_ram u_ram (
        .clk        (clk),
        .combin_res (combin_res),
        .ram_rd     (ram_rd),
        .ram_wr     (ram_wr),
        .rd_data    (rd_data)
    );

    hist_mem_arbiter u_arb (
        .bld_rd   (bld_rd),
        .ro_rd    (ro_rd),
        .bld_wr   (bld_wr),
        .ro_wr    (ro_wr),
        .ram_rd   (ram_rd),
        .ram_wr   (ram_wr),
        .rd_grant (rd_grant),
        .wr_grant (wr_grant)
    );

    hist_builder #(
        .HITS_PER_PIXEL  (HITS_PER_PIXEL),
        .FRAMES_PER_HIST (FRAMES_PER_HIST)
    ) u_bld (
        .clk         (clk),
        .combin_res  (combin_res),
        .hit_valid   (hit_valid),
        .hit_bin     (hit_bin),
        .bld_rd      (bld_rd),
        .bld_wr      (bld_wr),
        .rd_data     (rd_data),
        .hist_done   (hist_done),
        .done_bank   (done_bank),
        .active_bank (active_bank)
    );

    // readout only needs the grants, builder always wins
    hist_readout u_ro (
        .clk        (clk),
        .combin_res (combin_res),
        .hist_done  (hist_done),
        .done_bank  (done_bank),
        .ro_rd      (ro_rd),
        .ro_wr      (ro_wr),
        .rd_grant   (rd_grant),
        .wr_grant   (wr_grant),
        .rd_data    (rd_data),
        .ro_valid   (ro_valid),
        .ro_beat    (ro_beat),
        .ro_busy    (ro_busy)
    );

endmodule

`default_nettype wire

// ==== hist_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module hist_checker (
    input wire                   clk,
    input wire                   combin_res,
    input hist_pkg::mem_rd_req_t bld_rd,
    input hist_pkg::grant_e      rd_grant,
    input wire                   hist_done,
    input wire                   ro_valid,
    input wire                   ro_busy
);
    import hist_pkg::*;

    // failed assertions, read by the testbench at the end
    int assert_fails = 0;

    // builder always owns the read port when it asks
    a_bld_prio: assert property (@(posedge clk) disable iff (!combin_res)
        bld_rd.valid |-> (rd_grant != grant_readout))
    else begin
        $error("read port granted to readout while the builder requested it");
        assert_fails++;
    end

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!combin_res)
        hist_done |=> !hist_done)
    else begin
        $error("hist_done held high for more than one cycle");
        assert_fails++;
    end

    // beats only inside a readout
    a_beat_busy: assert property (@(posedge clk) disable iff (!combin_res)
        ro_valid |-> ro_busy)
    else begin
        $error("ro_valid seen while ro_busy is low");
        assert_fails++;
    end

endmodule

bind hist_top hist_checker u_chk (
    .clk        (clk),
    .combin_res (combin_res),
    .bld_rd     (bld_rd),
    .rd_grant   (rd_grant),
    .hist_done  (hist_done),
    .ro_valid   (ro_valid),
    .ro_busy    (ro_busy)
);

`default_nettype wire

// ==== hist_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module hist_tb;
    import hist_pkg::*;

    localparam int hits_pp   = 3;
    localparam int frames_ph = 2;
    localparam int n_bins    = 2 ** bin_w;
    localparam int n_pix     = 2 ** pix_w;
    localparam int hits_hist = hits_pp * n_pix * frames_ph;
    localparam int clk_per   = 8;
    localparam int n_entries = 9;

    // table row with bin source, hit count and idle cycles after each hit
    typedef struct packed {
        logic use_rand;
        bin_t bin;
        int   reps;
        int   gap;
    } stim_t;

    logic     clk = 1'b0;
    logic     combin_res;
    logic     hit_valid;
    bin_t     hit_bin;
    logic     hist_done;
    logic     active_bank;
    logic     ro_valid;
    ro_beat_t ro_beat;
    logic     ro_busy;

    stim_t       stim_table [n_entries];
    logic [31:0] lcg_state;
    int          wd_cycles;
    int          total_hits;
    logic        run_checks;

    // reference model state
    int       exp_cnt [2][n_pix * n_bins];
    int       model_hits;
    logic     model_bank;
    int       model_hists;
    int       done_seen;
    ro_beat_t beat_q [$];

    // readout end timing
    logic busy_q;
    time  last_beat_time;
    time  busy_fall_time;

    hist_top #(
        .HITS_PER_PIXEL  (hits_pp),
        .FRAMES_PER_HIST (frames_ph)
    ) u_hist_top (
        .clk         (clk),
        .combin_res  (combin_res),
        .hit_valid   (hit_valid),
        .hit_bin     (hit_bin),
        .hist_done   (hist_done),
        .active_bank (active_bank),
        .ro_valid    (ro_valid),
        .ro_beat     (ro_beat),
        .ro_busy     (ro_busy)
    );

    always #(clk_per / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string beat_str(input ro_beat_t b);
        return $sformatf("bank %0d pix %0d bin %0d count %0d", b.bank, b.pix, b.bin, b.count);
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_beat(input string name, input ro_beat_t exp, input ro_beat_t act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s expected {%s}, got {%s}",
                     $time, name, beat_str(exp), beat_str(act));
            stop_run();
        end
    endtask

    task automatic check_bank(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
            stop_run();
        end
    endtask

    // pixel follows the hit position within the frame
    // frames only decide when the histogram is complete
    task automatic model_hit(input bin_t b);
        int       pix;
        ro_beat_t beat;
        pix = (model_hits % (hits_pp * n_pix)) / hits_pp;
        exp_cnt[model_bank][pix * n_bins + int'(b)]++;
        model_hits++;
        if (model_hits == hits_hist) begin
            // beats in pixel-major order with zero bins included
            for (int i = 0; i < n_pix * n_bins; i++) begin
                beat.bank  = model_bank;
                beat.pix   = pix_t'(i / n_bins);
                beat.bin   = bin_t'(i % n_bins);
                beat.count = count_t'(exp_cnt[model_bank][i]);
                beat_q.push_back(beat);
                exp_cnt[model_bank][i] = 0;
            end
            model_hits  = 0;
            model_bank  = ~model_bank;
            model_hists++;
        end
    endtask

    task automatic send_hit(input bin_t b);
        @(negedge clk);
        hit_valid = 1'b1;
        hit_bin   = b;
        model_hit(b);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            hit_valid = 1'b0;
        end
    endtask

    // hist 1 runs back to back with no readout active
    // hist 2 and 3 arrive while the previous bank reads out
    // fixed-bin runs give three same-address hits in a row
    task automatic load_table();
        stim_table[0] = '{1'b1, 4'd0,  12, 0};
        stim_table[1] = '{1'b0, 4'd7,   6, 0};
        stim_table[2] = '{1'b1, 4'd0,   6, 0};
        stim_table[3] = '{1'b0, 4'd5,   6, 0};
        stim_table[4] = '{1'b1, 4'd0,  12, 4};
        stim_table[5] = '{1'b0, 4'd15,  6, 10};
        stim_table[6] = '{1'b0, 4'd0,   4, 0};
        stim_table[7] = '{1'b1, 4'd0,  16, 6};
        stim_table[8] = '{1'b0, 4'd9,   4, 12};
    endtask

    // output monitor sampled on the falling edge
    always @(negedge clk) begin
        if (run_checks) begin
            if (hist_done) begin
                done_seen++;
                if (done_seen != model_hists) begin
                    $display("hist_done pulsed with no matching completed histogram at %0t ns",
                             $time);
                    stop_run();
                end
            end
            // active bank only compared once the model and DUT agree on completions
            if (done_seen == model_hists) begin
                check_bank("active_bank", model_bank, active_bank);
            end
            if (model_hists == 0) begin
                check_flag("ro_valid", 1'b0, ro_valid);
                check_flag("ro_busy", 1'b0, ro_busy);
            end
            if (ro_valid) begin
                if (beat_q.size() == 0) begin
                    $display("readout beat {%s} arrived with no beat expected at %0t ns",
                             beat_str(ro_beat), $time);
                    stop_run();
                end else begin
                    check_beat("ro_beat", beat_q.pop_front(), ro_beat);
                    if (beat_q.size() == 0) begin
                        last_beat_time = $time;
                    end
                end
            end
            if (busy_q && !ro_busy) begin
                busy_fall_time = $time;
            end
            busy_q = ro_busy;
            if (u_hist_top.u_chk.assert_fails != 0) begin
                $display("a bound assertion on the DUT failed before %0t ns", $time);
                stop_run();
            end
        end
    end

    initial begin
        bin_t b;
        combin_res     = 1'b0;
        hit_valid      = 1'b0;
        hit_bin        = '0;
        run_checks     = 1'b0;
        lcg_state      = 32'h4cdf;
        model_hits     = 0;
        model_bank     = 1'b0;
        model_hists    = 0;
        done_seen      = 0;
        busy_q         = 1'b0;
        last_beat_time = 0;
        busy_fall_time = 0;
        foreach (exp_cnt[i, j]) begin
            exp_cnt[i][j] = 0;
        end
        load_table();

        // table cycles plus one full readout per histogram with 4x margin
        wd_cycles  = 0;
        total_hits = 0;
        for (int e = 0; e < n_entries; e++) begin
            wd_cycles  += stim_table[e].reps * (1 + stim_table[e].gap);
            total_hits += stim_table[e].reps;
        end
        wd_cycles = 4 * (wd_cycles + 64 * (total_hits / hits_hist));
        fork
            begin
                #(wd_cycles * clk_per);
                $display("watchdog expired after %0d cycles, the run hung", wd_cycles);
                stop_run();
            end
        join_none

        repeat (3) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
        run_checks = 1'b1;

        for (int e = 0; e < n_entries; e++) begin
            for (int r = 0; r < stim_table[e].reps; r++) begin
                if (stim_table[e].use_rand) begin
                    lcg_state = lcg_next(lcg_state);
                    b = lcg_state[19:16];
                end else begin
                    b = stim_table[e].bin;
                end
                send_hit(b);
                idle_cycles(stim_table[e].gap);
            end
        end
        idle_cycles(1);

        // wait for the last readout to finish
        while ((beat_q.size() != 0) || ro_busy) begin
            @(negedge clk);
        end
        idle_cycles(2);
        // with no hits left the last clear is never denied
        if (busy_fall_time != last_beat_time + clk_per) begin
            $display("ro_busy fell at %0t ns, expected one cycle after the last beat at %0t ns",
                     busy_fall_time, last_beat_time);
            stop_run();
        end

        if ((beat_q.size() == 0) && (done_seen == model_hists) &&
            (model_hists == total_hits / hits_hist) &&
            (u_hist_top.u_chk.assert_fails == 0)) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("run ended with %0d beats missing and %0d of %0d histograms done",
                     beat_q.size(), done_seen, model_hists);
            $display("%0d bound assertion failures", u_hist_top.u_chk.assert_fails);
            stop_run();
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
hist_pkg.sv
hist_bin_ram.sv
hist_mem_arbiter.sv
hist_builder.sv
hist_readout.sv
hist_top.sv
hist_checker.sv
hist_tb.sv

// ==== Bender.yml ====
package:
  name: hist

sources:
  - files:
      - hist_pkg.sv
      - hist_bin_ram.sv
      - hist_mem_arbiter.sv
      - hist_builder.sv
      - hist_readout.sv
      - hist_top.sv
  - target: simulation
    files:
      - hist_checker.sv
      - hist_tb.sv
